// File: verilog/trace_cache_pkg.sv
//============================================================
// Trace cache package
// Packet layout, cache geometry and buffer sizes shared by
// the trace driven data cache harness
//============================================================
`default_nettype none

package trace_cache_pkg;

  // Packet fields, opcode on top and data at the bottom
  localparam int ADDR_W       = 12;
  localparam int DATA_W       = 32;
  localparam int OP_W         = 2;
  localparam int PKT_W        = OP_W + ADDR_W + DATA_W;
  localparam int PKT_ADDR_LSB = DATA_W;
  localparam int PKT_OP_LSB   = DATA_W + ADDR_W;

  localparam logic [OP_W-1:0] OP_LOAD  = OP_W'(0);
  localparam logic [OP_W-1:0] OP_STORE = OP_W'(1);

  // Direct mapped geometry
  localparam int OFFSET_W    = 2;
  localparam int INDEX_W     = 4;
  localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
  localparam int LINE_WORDS  = 1 << OFFSET_W;
  localparam int NUM_LINES   = 1 << INDEX_W;
  localparam int LINE_ADDR_W = TAG_W + INDEX_W;

  // Buffers and backing store
  localparam int ROLLY_DEPTH  = 8;
  localparam int ROLLY_PTR_W  = $clog2(ROLLY_DEPTH);
  localparam int RESULT_DEPTH = 16;
  localparam int RESULT_PTR_W = $clog2(RESULT_DEPTH);
  localparam int MEM_LATENCY  = 4;
  localparam int MEM_LAT_W    = $clog2(MEM_LATENCY + 1);
  localparam int MEM_WORDS    = 1 << ADDR_W;

  typedef logic [PKT_W-1:0]  trace_pkt_t;
  typedef logic [ADDR_W-1:0] trace_addr_t;
  typedef logic [DATA_W-1:0] trace_word_t;
  typedef logic [TAG_W-1:0]  trace_tag_t;
  typedef logic [LINE_WORDS-1:0][DATA_W-1:0] trace_line_t;

  typedef enum logic [1:0] {READY, FILL_WAIT, REPLAY} dcache_state_e;

endpackage

`default_nettype wire

// File: verilog/trace_if.sv
//============================================================
// Trace cache links
// rolly_if carries packets from the rollback FIFO to the cache
// mem_if carries line fills and write-through stores
//============================================================
`default_nettype none

interface rolly_if
  import trace_cache_pkg::*;
  ();

  trace_pkt_t pkt;
  logic       v;
  logic       yumi;
  logic       roll;
  logic       ckpt;

  modport fifo  (output pkt, output v, input yumi, input roll, input ckpt);
  modport cache (input pkt, input v, output yumi, output roll, output ckpt);

endinterface

interface mem_if
  import trace_cache_pkg::*;
  ();

  logic                   fill_req;
  logic [LINE_ADDR_W-1:0] fill_addr;
  logic                   fill_v;
  trace_line_t            fill_line;
  logic                   wr_en;
  trace_addr_t            wr_addr;
  trace_word_t            wr_data;

  modport cache (output fill_req, output fill_addr, input fill_v, input fill_line,
                 output wr_en, output wr_addr, output wr_data);
  modport mem   (input fill_req, input fill_addr, output fill_v, output fill_line,
                 input wr_en, input wr_addr, input wr_data);

endinterface

`default_nettype wire

// File: verilog/rolly_fifo.sv
//============================================================
// Rollback FIFO
// Circular packet buffer with read, write and checkpoint
// pointers. A roll rewinds reads to the last commit point
//============================================================
`default_nettype none

module rolly_fifo
  import trace_cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  trace_pkt_t pkt_i,
  input  logic       pkt_v_i,
  output logic       pkt_yumi_o,
  rolly_if.fifo      deq
);

  trace_pkt_t buf_r [ROLLY_DEPTH];

  // Pointers carry a wrap bit on top
  logic [ROLLY_PTR_W:0] wptr_r;
  logic [ROLLY_PTR_W:0] rptr_r;
  logic [ROLLY_PTR_W:0] cptr_r;

  logic full;
  logic has_data;

  // Full against the checkpoint, so slots free only on commit
  assign full = (wptr_r[ROLLY_PTR_W] != cptr_r[ROLLY_PTR_W]) &&
                (wptr_r[ROLLY_PTR_W-1:0] == cptr_r[ROLLY_PTR_W-1:0]);

  assign has_data = (rptr_r != wptr_r);

  assign pkt_yumi_o = pkt_v_i && !full;

  assign deq.pkt = buf_r[rptr_r[ROLLY_PTR_W-1:0]];
  // Hidden from the cache while rewinding
  assign deq.v   = has_data && !deq.roll;

  always_ff @(posedge clk_i)
  begin
    if (pkt_yumi_o)
    begin
      buf_r[wptr_r[ROLLY_PTR_W-1:0]] <= pkt_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end
    else
    begin
      if (pkt_yumi_o)
      begin
        wptr_r <= wptr_r + 1'b1;
      end

      if (deq.roll)
      begin
        rptr_r <= cptr_r;
      end
      else if (deq.yumi)
      begin
        rptr_r <= rptr_r + 1'b1;
      end

      // Oldest consumed packet retires
      if (deq.ckpt)
      begin
        cptr_r <= cptr_r + 1'b1;
      end
    end
  end

  // A commit only retires a packet the cache already took
  ckpt_behind_read_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    deq.ckpt |-> (cptr_r != rptr_r)
  );

  roll_yumi_excl_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(deq.roll && deq.yumi)
  );

endmodule

`default_nettype wire

// File: verilog/trace_dcache.sv
//============================================================
// Trace data cache
// Two stage direct mapped write-through cache. A load miss
// rolls the input FIFO back, fills the line, then replays
//============================================================
`default_nettype none

module trace_dcache
  import trace_cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  rolly_if.cache      deq,
  mem_if.cache        mem,
  output trace_word_t res_data_o,
  output logic        res_push_o,
  input  logic        res_space_i
);

  dcache_state_e state_r;

  trace_tag_t           tag_r  [NUM_LINES];
  trace_line_t          data_r [NUM_LINES];
  logic [NUM_LINES-1:0] valid_r;

  // Stage 1 packet
  trace_pkt_t s1_pkt_r;
  logic       s1_v_r;

  logic [OP_W-1:0]     s1_op;
  trace_addr_t         s1_addr;
  trace_word_t         s1_data;
  trace_tag_t          s1_tag;
  logic [INDEX_W-1:0]  s1_idx;
  logic [OFFSET_W-1:0] s1_off;
  logic                s1_hit;
  logic                s1_is_load;
  logic                s1_is_store;
  logic                load_miss;
  logic                fill_write;

  assign s1_op   = s1_pkt_r[PKT_OP_LSB +: OP_W];
  assign s1_addr = s1_pkt_r[PKT_ADDR_LSB +: ADDR_W];
  assign s1_data = s1_pkt_r[DATA_W-1:0];
  assign s1_off  = s1_addr[OFFSET_W-1:0];
  assign s1_idx  = s1_addr[OFFSET_W +: INDEX_W];
  assign s1_tag  = s1_addr[ADDR_W-1 -: TAG_W];

  assign s1_hit      = valid_r[s1_idx] && (tag_r[s1_idx] == s1_tag);
  assign s1_is_load  = s1_v_r && (s1_op == OP_LOAD);
  assign s1_is_store = s1_v_r && (s1_op == OP_STORE);
  assign load_miss   = s1_is_load && !s1_hit;
  assign fill_write  = (state_r == FILL_WAIT) && mem.fill_v;

  // Stage 0 takes the FIFO head
  assign deq.yumi = deq.v && (state_r == READY) && res_space_i;
  assign deq.roll = load_miss;
  assign deq.ckpt = s1_v_r && !load_miss;

  assign res_push_o = s1_is_load && s1_hit;
  assign res_data_o = data_r[s1_idx][s1_off];

  assign mem.fill_req  = load_miss;
  assign mem.fill_addr = s1_addr[ADDR_W-1:OFFSET_W];
  assign mem.wr_en     = s1_is_store;
  assign mem.wr_addr   = s1_addr;
  assign mem.wr_data   = s1_data;

  // Payload holds through a fill, it still names the missed line
  always_ff @(posedge clk_i)
  begin
    if (deq.yumi)
    begin
      s1_pkt_r <= deq.pkt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_r  <= 1'b0;
      valid_r <= '0;
      state_r <= READY;
    end
    else
    begin
      // Poison whatever stage 0 took behind a miss
      s1_v_r <= deq.yumi && !load_miss;

      if (fill_write)
      begin
        valid_r[s1_idx] <= 1'b1;
      end

      case (state_r)
        READY:
        begin
          if (load_miss)
          begin
            state_r <= FILL_WAIT;
          end
        end
        FILL_WAIT:
        begin
          if (mem.fill_v)
          begin
            state_r <= REPLAY;
          end
        end
        REPLAY:  state_r <= READY;
        default: state_r <= READY;
      endcase
    end
  end

  // Store hits update in place, misses skip allocation
  always_ff @(posedge clk_i)
  begin
    if (fill_write)
    begin
      tag_r[s1_idx]  <= s1_tag;
      data_r[s1_idx] <= mem.fill_line;
    end
    else if (s1_is_store && s1_hit)
    begin
      data_r[s1_idx][s1_off] <= s1_data;
    end
  end

  yumi_in_ready_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    deq.yumi |-> (state_r == READY)
  );

  // Result slot was reserved when the packet was accepted
  push_had_space_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    res_push_o |-> $past(deq.yumi && res_space_i)
  );

endmodule

`default_nettype wire

// File: verilog/mock_mem.sv
//============================================================
// Mock backing memory
// Word array with a write-through port and a fixed latency
// line fill, one fill outstanding
//============================================================
`default_nettype none

module mock_mem
  import trace_cache_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  mem_if.mem   mem
);

  // Starts cleared in simulation
  trace_word_t mem_r [MEM_WORDS] = '{default: '0};

  logic                   pend_r;
  logic [MEM_LAT_W-1:0]   cnt_r;
  logic [LINE_ADDR_W-1:0] line_r;

  assign mem.fill_v = pend_r && (cnt_r == '0);

  always_comb
  begin
    for (int k = 0; k < LINE_WORDS; k++)
    begin
      mem.fill_line[k] = mem_r[{line_r, OFFSET_W'(k)}];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (mem.wr_en)
    begin
      mem_r[mem.wr_addr] <= mem.wr_data;
    end
    if (mem.fill_req)
    begin
      line_r <= mem.fill_addr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pend_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (mem.fill_req)
    begin
      pend_r <= 1'b1;
      cnt_r  <= MEM_LAT_W'(MEM_LATENCY - 1);
    end
    else if (pend_r)
    begin
      if (cnt_r == '0)
        pend_r <= 1'b0;
      else
        cnt_r <= cnt_r - 1'b1;
    end
  end

  no_overlap_fill_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem.fill_req |-> !pend_r
  );

endmodule

`default_nettype wire

// File: verilog/result_fifo.sv
//============================================================
// Result FIFO
// Holds load results in trace order for the valid/ready
// output port, flags room for two more entries
//============================================================
`default_nettype none

module result_fifo
  import trace_cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        push_i,
  input  trace_word_t data_i,
  output logic        space_o,
  output trace_word_t data_o,
  output logic        v_o,
  input  logic        ready_i
);

  trace_word_t buf_r [RESULT_DEPTH];

  logic [RESULT_PTR_W-1:0] wr_ptr_r;
  logic [RESULT_PTR_W-1:0] rd_ptr_r;
  logic [RESULT_PTR_W:0]   count_r;
  logic                    pop;

  assign v_o    = (count_r != '0);
  assign data_o = buf_r[rd_ptr_r];
  assign pop    = v_o && ready_i;

  // One slot for stage 1, one for the packet being taken
  assign space_o = (count_r <= (RESULT_PTR_W + 1)'(RESULT_DEPTH - 2));

  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      buf_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= rd_ptr_r + 1'b1;

      case ({push_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  no_push_full_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_r != (RESULT_PTR_W + 1)'(RESULT_DEPTH))
  );

endmodule

`default_nettype wire

// File: verilog/trace_cache_top.sv
//============================================================
// Trace cache harness top
// Rollback FIFO, data cache, backing memory and result FIFO
//============================================================
`default_nettype none

module trace_cache_top
  import trace_cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  trace_pkt_t  tr_pkt_i,
  input  logic        tr_pkt_v_i,
  output logic        tr_pkt_yumi_o,
  output trace_word_t tr_data_o,
  output logic        tr_data_v_o,
  input  logic        tr_data_ready_i
);

  rolly_if rolly_bus ();
  mem_if   mem_bus ();

  trace_word_t res_data;
  logic        res_push;
  logic        res_space;

  rolly_fifo rolly_fifo_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pkt_i      (tr_pkt_i),
    .pkt_v_i    (tr_pkt_v_i),
    .pkt_yumi_o (tr_pkt_yumi_o),
    .deq        (rolly_bus)
  );

  trace_dcache trace_dcache_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .deq         (rolly_bus),
    .mem         (mem_bus),
    .res_data_o  (res_data),
    .res_push_o  (res_push),
    .res_space_i (res_space)
  );

  mock_mem mock_mem_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .mem     (mem_bus)
  );

  result_fifo result_fifo_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (res_push),
    .data_i  (res_data),
    .space_o (res_space),
    .data_o  (tr_data_o),
    .v_o     (tr_data_v_o),
    .ready_i (tr_data_ready_i)
  );

endmodule

`default_nettype wire

// File: dv/trace_cache_tb.sv
//============================================================
// Trace cache harness testbench
// Drives LFSR trace packets, models memory in trace order and
// checks every load result, with output back-pressure
//============================================================
`default_nettype none

module trace_cache_tb
  import trace_cache_pkg::*;
  ();

  localparam int N_FRESH   = 24;
  localparam int N_STLD    = 50;
  localparam int N_THRASH  = 34;
  localparam int N_MIX     = 200;
  localparam int N_BURST   = 40;
  localparam int N_BP      = 200;
  localparam int N_LAT     = 2;
  localparam int N_TOTAL   = N_FRESH + N_STLD + N_THRASH + N_MIX + N_BURST + N_BP + N_LAT;
  localparam int SETTLE    = MEM_LATENCY + 10;
  localparam int TIMEOUT   = N_TOTAL * (MEM_LATENCY + 10) * 10 + 20000;

  logic        clk_i;
  logic        rst_n_i;
  trace_pkt_t  tr_pkt_i;
  logic        tr_pkt_v_i;
  logic        tr_pkt_yumi_o;
  trace_word_t tr_data_o;
  logic        tr_data_v_o;
  logic        tr_data_ready_i;

  trace_word_t ref_mem [MEM_WORDS];
  trace_word_t exp_q [$];
  trace_word_t exp_word;
  logic [15:0] lfsr_r;
  logic        bp_en;
  logic        rst_v_seen;
  int          err_count;
  int          pass_count;
  int          fail_count;

  trace_cache_top trace_cache_top_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .tr_pkt_i        (tr_pkt_i),
    .tr_pkt_v_i      (tr_pkt_v_i),
    .tr_pkt_yumi_o   (tr_pkt_yumi_o),
    .tr_data_o       (tr_data_o),
    .tr_data_v_o     (tr_data_v_o),
    .tr_data_ready_i (tr_data_ready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // x^16 + x^15 + x^13 + x^4 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[14] ^ s[12] ^ s[3];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_r = lfsr_next(lfsr_r);
      v = {v[30:0], lfsr_r[0]};
    end
    return v;
  endfunction

  // Memory model in trace order, returns the word a load would see
  function automatic trace_word_t ref_apply(input logic [OP_W-1:0] op, input trace_addr_t addr,
                                            input trace_word_t data);
    if (op == OP_STORE)
      ref_mem[addr] = data;
    return ref_mem[addr];
  endfunction

  // Called at posedge + 1, returns at posedge + 1 after the handshake
  task automatic send_pkt(input logic [OP_W-1:0] op, input trace_addr_t addr,
                          input trace_word_t data);
    trace_word_t exp;
    exp = ref_apply(op, addr, data);
    if (op == OP_LOAD)
      exp_q.push_back(exp);
    tr_pkt_i   = {op, addr, data};
    tr_pkt_v_i = 1'b1;
    @(negedge clk_i);
    while (!tr_pkt_yumi_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    tr_pkt_v_i = 1'b0;
  endtask

  task automatic send_random_pkt();
    logic [31:0] op_bits;
    logic [31:0] tag_bits;
    logic [31:0] low_bits;
    logic [31:0] data_bits;
    op_bits   = take_bits(2);
    tag_bits  = take_bits(2);
    low_bits  = take_bits(6);
    data_bits = take_bits(32);
    // Four tags over all lines, so hits and conflicts both occur
    send_pkt(op_bits[1:0], {tag_bits[1:0], 4'b0000, low_bits[5:0]}, data_bits);
  endtask

  task automatic drain();
    while (exp_q.size() != 0)
      @(negedge clk_i);
    repeat (SETTLE) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input string name, input int start_errs);
    if (err_count == start_errs)
    begin
      pass_count++;
      $display("test %-24s ok", name);
    end
    else
    begin
      fail_count++;
      $display("test %-24s fail (%0d errors)", name, err_count - start_errs);
    end
  endtask

  // Result checker, samples mid cycle where outputs are settled
  always @(negedge clk_i)
  begin
    if (!rst_n_i && tr_data_v_o !== 1'b0)
      rst_v_seen = 1'b1;
    if (rst_n_i && !tr_pkt_v_i && tr_pkt_yumi_o)
    begin
      err_count++;
      $display("Input yumi was high with no packet offered");
    end
    if (rst_n_i && tr_data_v_o && tr_data_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        err_count++;
        $display("A result came out with no load outstanding (data %08h)", tr_data_o);
      end
      else
      begin
        exp_word = exp_q.pop_front();
        if (tr_data_o !== exp_word)
        begin
          err_count++;
          $display("FAIL tr_data_o expected %08h got %08h", exp_word, tr_data_o);
        end
      end
    end
  end

  // Output back-pressure, ready about one cycle in four
  initial
  begin
    logic [31:0] bit_v;
    logic        nxt;
    tr_data_ready_i = 1'b1;
    forever
    begin
      @(negedge clk_i);
      nxt = 1'b1;
      if (bp_en)
      begin
        bit_v = take_bits(2);
        nxt = bit_v[1] & bit_v[0];
      end
      @(posedge clk_i);
      #1;
      tr_data_ready_i = nxt;
    end
  end

  initial
  begin
    #(TIMEOUT);
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    int          start;
    int          lat;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    trace_addr_t addr_a;
    trace_addr_t addr_b;

    tr_pkt_i   = '0;
    tr_pkt_v_i = 1'b0;
    rst_n_i    = 1'b0;
    bp_en      = 1'b0;
    rst_v_seen = 1'b0;
    lfsr_r     = 16'd59825;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    for (int i = 0; i < MEM_WORDS; i++)
      ref_mem[i] = '0;

    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #1;

    start = err_count;
    for (int i = 0; i < N_FRESH; i++)
    begin
      r_addr = take_bits(ADDR_W);
      send_pkt(OP_LOAD, r_addr[ADDR_W-1:0], '0);
    end
    drain();
    finish_test("fresh loads", start);

    // Fill then store hits, then store misses with no allocate
    start = err_count;
    for (int i = 0; i < 10; i++)
    begin
      r_addr = take_bits(ADDR_W);
      r_data = take_bits(DATA_W);
      send_pkt(OP_LOAD, r_addr[ADDR_W-1:0], '0);
      send_pkt(OP_STORE, r_addr[ADDR_W-1:0], r_data);
      send_pkt(OP_LOAD, r_addr[ADDR_W-1:0], '0);
    end
    for (int i = 0; i < 10; i++)
    begin
      r_addr = take_bits(ADDR_W);
      r_data = take_bits(DATA_W);
      send_pkt(OP_STORE, r_addr[ADDR_W-1:0], r_data);
      send_pkt(OP_LOAD, r_addr[ADDR_W-1:0], '0);
    end
    drain();
    finish_test("store then load", start);

    // Same index 9, tags 0x05 and 0x2a, every load evicts the other
    start = err_count;
    addr_a = {6'h05, 4'h9, 2'h1};
    addr_b = {6'h2a, 4'h9, 2'h2};
    send_pkt(OP_STORE, addr_a, 32'hA5A5_0001);
    send_pkt(OP_STORE, addr_b, 32'h5A5A_0002);
    for (int i = 0; i < N_THRASH - 2; i++)
      send_pkt(OP_LOAD, (i % 2 == 0) ? addr_a : addr_b, '0);
    drain();
    finish_test("conflict rollback", start);

    start = err_count;
    for (int i = 0; i < N_MIX; i++)
      send_random_pkt();
    drain();
    finish_test("random mix", start);

    start = err_count;
    if (rst_v_seen)
    begin
      err_count++;
      $display("Output valid was high while reset was asserted");
    end
    bp_en = 1'b1;
    // Hits on one line outrun the output and fill the result FIFO
    for (int i = 0; i < N_BURST; i++)
      send_pkt(OP_LOAD, 12'h5a8, '0);
    for (int i = 0; i < N_BP; i++)
      send_random_pkt();
    while (exp_q.size() != 0)
      @(negedge clk_i);
    bp_en = 1'b0;
    drain();
    finish_test("back-pressure", start);

    // Line filled first, then a lone hit is timed
    start = err_count;
    send_pkt(OP_LOAD, 12'h3c4, '0);
    drain();
    void'(ref_apply(OP_LOAD, 12'h3c4, '0));
    exp_q.push_back(ref_mem[12'h3c4]);
    tr_pkt_i   = {OP_LOAD, 12'h3c4, 32'h0};
    tr_pkt_v_i = 1'b1;
    @(negedge clk_i);
    while (!tr_pkt_yumi_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #1;
    tr_pkt_v_i = 1'b0;
    lat = 0;
    do
    begin
      @(negedge clk_i);
      lat++;
    end
    while (!tr_data_v_o && lat < SETTLE);
    if (lat != 3)
    begin
      err_count++;
      $display("FAIL tr_data_v_o latency expected 0x3 got 0x%0h", lat);
    end
    drain();
    finish_test("hit latency", start);

    $display("tests passed %0d failed %0d, check errors %0d", pass_count, fail_count,
             err_count);
    if (fail_count == 0 && err_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
verilog/trace_cache_pkg.sv
verilog/trace_if.sv
verilog/rolly_fifo.sv
verilog/trace_dcache.sv
verilog/mock_mem.sv
verilog/result_fifo.sv
verilog/trace_cache_top.sv
dv/trace_cache_tb.sv

// File: Makefile
TOP := trace_cache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
